// ==== src/mem_access_params.svh ====
// Memory access unit parameters
`ifndef MEM_ACCESS_PARAMS_SVH
`define MEM_ACCESS_PARAMS_SVH

// Width of one memory word
`define MEM_DATA_W 32

// Width of a byte address
`define MEM_ADDR_W 16

// Access-phase cycles allowed before a transfer is abandoned
`define MEM_BUS_TIMEOUT 16

`endif

// ==== src/mem_access_pkg.sv ====
// Memory access unit types
`include "mem_access_params.svh"

package mem_access_pkg;

    typedef logic [`MEM_DATA_W-1:0] mem_data_t;
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`MEM_DATA_W-1:0] lane_mask_t;
    typedef logic [4:0]             bit_shift_t;

    typedef enum logic [1:0]
    {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_TAS   = 2'd2
    } mem_op_t;

    // Size is log2 of the byte count
    typedef enum logic [1:0]
    {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0]
    {
        ERR_NONE    = 2'd0,
        ERR_ALIGN   = 2'd1,
        ERR_SLAVE   = 2'd2,
        ERR_TIMEOUT = 2'd3
    } mem_err_t;

    typedef enum logic [2:0]
    {
        ST_IDLE      = 3'd0,
        ST_RD_SETUP  = 3'd1,
        ST_RD_ACCESS = 3'd2,
        ST_WR_SETUP  = 3'd3,
        ST_WR_ACCESS = 3'd4,
        ST_RESPOND   = 3'd5
    } access_state_t;

    typedef struct packed
    {
        mem_op_t   op;
        mem_size_t size;
        mem_addr_t addr;
        mem_data_t wdata;
    } mem_req_t;

    typedef struct packed
    {
        mem_data_t rdata;
        mem_err_t  err;
    } mem_rsp_t;

    typedef struct packed
    {
        logic      psel;
        logic      penable;
        logic      pwrite;
        mem_addr_t paddr;
        mem_data_t pwdata;
    } apb_req_t;

    typedef struct packed
    {
        logic      pready;
        logic      pslverr;
        mem_data_t prdata;
    } apb_rsp_t;

endpackage

// ==== src/lane_align.sv ====
// Lane mask and shift generation
`timescale 1ns/1ns

module lane_align
(
    input  mem_access_pkg::mem_addr_t  addr,
    input  mem_access_pkg::mem_size_t  size,
    output mem_access_pkg::lane_mask_t mask,
    output mem_access_pkg::bit_shift_t shift,
    output logic                       misaligned
);
    import mem_access_pkg::*;

    logic [1:0] byte_off;
    lane_mask_t size_mask;

    // Byte offset within the word, turned into bits
    assign byte_off = addr[1:0];
    assign shift    = {byte_off, 3'b000};

    always_comb
    begin
        case (size)
            SIZE_BYTE:
            begin
                size_mask  = lane_mask_t'(32'h0000_00ff);
                misaligned = 1'b0;
            end
            SIZE_HALF:
            begin
                size_mask  = lane_mask_t'(32'h0000_ffff);
                misaligned = byte_off[0];
            end
            default:
            begin
                // Word, and the unused encoding treated the same way
                size_mask  = lane_mask_t'(32'hffff_ffff);
                misaligned = |byte_off;
            end
        endcase
    end

    assign mask = size_mask << shift;

endmodule

// ==== src/load_extract.sv ====
// Load value extraction
`timescale 1ns/1ns

module load_extract
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       capture,
    input  mem_access_pkg::mem_data_t  rdata_word,
    input  mem_access_pkg::lane_mask_t mask,
    input  mem_access_pkg::bit_shift_t shift,
    output mem_access_pkg::mem_data_t  value
);
    import mem_access_pkg::*;

    mem_data_t lanes;

    // Keep the addressed lanes and bring them down to bit 0
    assign lanes = (rdata_word & mask) >> shift;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            value <= '0;
        end
        else if (capture)
        begin
            value <= lanes;
        end
    end

endmodule

// ==== src/store_merge.sv ====
// Read-modify-write data merge
`timescale 1ns/1ns

module store_merge
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       capture,
    input  mem_access_pkg::mem_data_t  old_word,
    input  mem_access_pkg::mem_data_t  new_data,
    input  mem_access_pkg::lane_mask_t mask,
    input  mem_access_pkg::bit_shift_t shift,
    output mem_access_pkg::mem_data_t  merged
);
    import mem_access_pkg::*;

    mem_data_t placed;
    mem_data_t next_word;

    // New lanes moved up to their byte position
    assign placed = (new_data << shift) & mask;

    // Untouched lanes keep what the read returned
    assign next_word = (old_word & ~mask) | placed;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            merged <= '0;
        end
        else if (capture)
        begin
            merged <= next_word;
        end
    end

endmodule

// ==== src/bus_wait_timer.sv ====
// APB access-phase wait timer
`timescale 1ns/1ns
`include "mem_access_params.svh"

module bus_wait_timer
(
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic count_en,
    output logic timeout
);
    localparam int CNT_W = $clog2(`MEM_BUS_TIMEOUT + 1);

    logic [CNT_W-1:0] count;

    // Saturates at the limit so timeout stays up until cleared
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0;
        end
        else if (count_en && !timeout)
        begin
            count <= count + 1'b1;
        end
    end

    assign timeout = (count == CNT_W'(`MEM_BUS_TIMEOUT));

endmodule

// ==== src/mem_access_fsm.sv ====
// Memory access sequencing FSM
`timescale 1ns/1ns

module mem_access_fsm
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  mem_access_pkg::mem_req_t   req,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output mem_access_pkg::mem_rsp_t   rsp,
    output mem_access_pkg::apb_req_t   apb,
    input  mem_access_pkg::apb_rsp_t   apb_rsp,
    input  logic                       misaligned,
    input  mem_access_pkg::mem_data_t  load_value,
    input  mem_access_pkg::mem_data_t  merged,
    input  logic                       timeout,
    output mem_access_pkg::mem_req_t   cur_req,
    output logic                       capture,
    output logic                       timer_clear,
    output logic                       timer_en
);
    import mem_access_pkg::*;

    access_state_t state;
    access_state_t state_next;
    mem_err_t      err;
    mem_err_t      err_next;
    logic          accept;
    logic          rmw_op;

    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid && req_ready;

    // Stores and test-and-set both need the write half
    assign rmw_op = (cur_req.op != OP_LOAD);

    always_comb
    begin
        state_next = state;
        err_next   = err;
        case (state)
            ST_IDLE:
            begin
                if (accept)
                begin
                    state_next = ST_RD_SETUP;
                    err_next   = ERR_NONE;
                end
            end
            ST_RD_SETUP:
            begin
                // Misaligned requests never reach the bus
                if (misaligned)
                begin
                    state_next = ST_RESPOND;
                    err_next   = ERR_ALIGN;
                end
                else
                begin
                    state_next = ST_RD_ACCESS;
                end
            end
            ST_RD_ACCESS:
            begin
                if (apb_rsp.pready)
                begin
                    if (apb_rsp.pslverr)
                    begin
                        state_next = ST_RESPOND;
                        err_next   = ERR_SLAVE;
                    end
                    else if (rmw_op)
                    begin
                        state_next = ST_WR_SETUP;
                    end
                    else
                    begin
                        state_next = ST_RESPOND;
                    end
                end
                else if (timeout)
                begin
                    state_next = ST_RESPOND;
                    err_next   = ERR_TIMEOUT;
                end
            end
            ST_WR_SETUP:
            begin
                state_next = ST_WR_ACCESS;
            end
            ST_WR_ACCESS:
            begin
                if (apb_rsp.pready)
                begin
                    state_next = ST_RESPOND;
                    if (apb_rsp.pslverr)
                    begin
                        err_next = ERR_SLAVE;
                    end
                end
                else if (timeout)
                begin
                    state_next = ST_RESPOND;
                    err_next   = ERR_TIMEOUT;
                end
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= ST_IDLE;
            err   <= ERR_NONE;
        end
        else
        begin
            state <= state_next;
            err   <= err_next;
        end
    end

    // Test-and-set always writes the value 1 into its lanes
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_req <= req;
            if (req.op == OP_TAS)
            begin
                cur_req.wdata <= mem_data_t'(1);
            end
        end
    end

    // Data modules latch the read word on the completing edge
    assign capture     = (state == ST_RD_ACCESS) && apb_rsp.pready;
    assign timer_clear = (state == ST_RD_SETUP) || (state == ST_WR_SETUP);
    assign timer_en    = (state == ST_RD_ACCESS) || (state == ST_WR_ACCESS);

    always_comb
    begin
        apb.psel    = ((state == ST_RD_SETUP) && !misaligned) ||
                      (state == ST_RD_ACCESS) ||
                      (state == ST_WR_SETUP) ||
                      (state == ST_WR_ACCESS);
        apb.penable = (state == ST_RD_ACCESS) || (state == ST_WR_ACCESS);
        apb.pwrite  = (state == ST_WR_SETUP) || (state == ST_WR_ACCESS);
        apb.paddr   = cur_req.addr & ~mem_addr_t'(3);
        apb.pwdata  = merged;
    end

    assign rsp_valid = (state == ST_RESPOND);
    assign rsp.rdata = load_value;
    assign rsp.err   = err;

endmodule

// ==== src/mem_access_top.sv ====
// Data memory access unit
`timescale 1ns/1ns

module mem_access_top
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  mem_access_pkg::mem_req_t req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output mem_access_pkg::mem_rsp_t rsp,
    output mem_access_pkg::apb_req_t apb,
    input  mem_access_pkg::apb_rsp_t apb_rsp
);
    import mem_access_pkg::*;

    mem_req_t   cur_req;
    lane_mask_t mask;
    bit_shift_t shift;
    mem_data_t  load_value;
    mem_data_t  merged;
    logic       misaligned;
    logic       capture;
    logic       timer_clear;
    logic       timer_en;
    logic       timeout;

    mem_access_fsm fsm_inst
    (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .apb         (apb),
        .apb_rsp     (apb_rsp),
        .misaligned  (misaligned),
        .load_value  (load_value),
        .merged      (merged),
        .timeout     (timeout),
        .cur_req     (cur_req),
        .capture     (capture),
        .timer_clear (timer_clear),
        .timer_en    (timer_en)
    );

    lane_align lane_align_inst
    (
        .addr       (cur_req.addr),
        .size       (cur_req.size),
        .mask       (mask),
        .shift      (shift),
        .misaligned (misaligned)
    );

    // Read word goes straight from the bus into both data modules
    load_extract load_extract_inst
    (
        .clk        (clk),
        .reset      (reset),
        .capture    (capture),
        .rdata_word (apb_rsp.prdata),
        .mask       (mask),
        .shift      (shift),
        .value      (load_value)
    );

    store_merge store_merge_inst
    (
        .clk      (clk),
        .reset    (reset),
        .capture  (capture),
        .old_word (apb_rsp.prdata),
        .new_data (cur_req.wdata),
        .mask     (mask),
        .shift    (shift),
        .merged   (merged)
    );

    bus_wait_timer bus_wait_timer_inst
    (
        .clk      (clk),
        .reset    (reset),
        .clear    (timer_clear),
        .count_en (timer_en),
        .timeout  (timeout)
    );

endmodule

// ==== tb/apb_mem_model.sv ====
// APB slave memory model
`timescale 1ns/1ns

module apb_mem_model
(
    input  logic                      clk,
    input  logic                      reset,
    input  mem_access_pkg::apb_req_t  apb,
    output mem_access_pkg::apb_rsp_t  apb_rsp,
    input  logic                      stall,
    input  logic [2:0]                wait_states,
    input  mem_access_pkg::mem_addr_t err_lo,
    input  mem_access_pkg::mem_addr_t err_hi
);
    import mem_access_pkg::*;

    mem_data_t  mem [256];
    int         wait_left;
    logic [7:0] idx;
    logic       in_window;

    // Initial image that differs in every word
    function automatic mem_data_t fill_word(input int i);
        logic [7:0] a;
        a = 8'(i);
        return {a ^ 8'ha5, ~a, a + 8'h3c, a};
    endfunction

    assign idx       = apb.paddr[9:2];
    assign in_window = (apb.paddr >= err_lo) && (apb.paddr <= err_hi);

    initial
    begin
        for (int i = 0; i < 256; i++)
        begin
            mem[i] <= fill_word(i);
        end
        apb_rsp   <= '0;
        wait_left <= 0;
    end

    // Slave outputs change on the falling edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            apb_rsp   <= '0;
            wait_left <= 0;
        end
        else if (apb.psel && !apb.penable)
        begin
            // Setup phase picks the wait states of this transfer
            apb_rsp   <= '0;
            wait_left <= int'(wait_states);
        end
        else if (apb.psel && apb.penable && !apb_rsp.pready)
        begin
            if (wait_left != 0)
            begin
                wait_left <= wait_left - 1;
            end
            else if (!stall)
            begin
                apb_rsp.pready  <= 1'b1;
                apb_rsp.pslverr <= in_window;
                apb_rsp.prdata  <= mem[idx];
                if (apb.pwrite && !in_window)
                begin
                    mem[idx] <= apb.pwdata;
                end
            end
        end
        else
        begin
            apb_rsp <= '0;
        end
    end

endmodule

// ==== tb/tb_mem_access.sv ====
// Memory access unit testbench
`timescale 1ns/1ns
`include "mem_access_params.svh"

module tb_mem_access;
    import mem_access_pkg::*;

    localparam int          READY_LIMIT = 8;
    localparam int          RSP_LIMIT   = 2 * (`MEM_BUS_TIMEOUT + 4) + 8;
    localparam logic [31:0] SEED        = 32'hc018_d4ae;
    localparam mem_addr_t   WIN_LO      = 16'h0380;
    localparam mem_addr_t   WIN_HI      = 16'h03ff;

    logic        clk;
    logic        reset;
    logic        req_valid;
    mem_req_t    req;
    logic        req_ready;
    logic        rsp_valid;
    mem_rsp_t    rsp;
    apb_req_t    apb;
    apb_rsp_t    apb_rsp;
    logic        stall;
    logic [2:0]  wait_states;
    mem_addr_t   err_lo;
    mem_addr_t   err_hi;
    logic [31:0] rng;
    mem_data_t   ref_mem [256];

    mem_access_top mem_access_top_inst
    (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .apb       (apb),
        .apb_rsp   (apb_rsp)
    );

    apb_mem_model apb_mem_model_inst
    (
        .clk         (clk),
        .reset       (reset),
        .apb         (apb),
        .apb_rsp     (apb_rsp),
        .stall       (stall),
        .wait_states (wait_states),
        .err_lo      (err_lo),
        .err_hi      (err_hi)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic mem_size_t random_size();
        return mem_size_t'(next_random() % 3);
    endfunction

    // Random address in a byte range aligned to the size
    function automatic mem_addr_t random_addr(input mem_addr_t base, input int span,
                                              input mem_size_t size);
        mem_addr_t a;
        a = base + mem_addr_t'(next_random() % span);
        return a & ~mem_addr_t'((1 << int'(size)) - 1);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "first error reached");
    endtask

    task automatic compare_data(input string what, input mem_data_t got, input mem_data_t exp);
        if (got !== exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic compare_err(input string what, input mem_err_t got, input mem_err_t exp);
        if (got !== exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %s expected %s",
                                     $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    // Zero-extended lanes of a word as the CPU sees them
    function automatic mem_data_t lane_value(input mem_data_t word, input mem_addr_t addr,
                                             input mem_size_t size);
        int off;
        off = int'(addr[1:0]);
        case (size)
            SIZE_BYTE: return {24'h0, word[off*8 +: 8]};
            SIZE_HALF: return {16'h0, word[off*8 +: 16]};
            default:   return word;
        endcase
    endfunction

    task automatic write_lanes(input mem_addr_t addr, input mem_size_t size,
                               input mem_data_t data);
        int off;
        int idx;
        int b;
        off = int'(addr[1:0]);
        idx = int'(addr[9:2]);
        for (b = 0; b < (1 << int'(size)); b++)
        begin
            ref_mem[idx][(off + b)*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    // Starts just after a falling edge and returns one cycle after the response
    task automatic run_request(input mem_op_t op, input mem_size_t size, input mem_addr_t addr,
                               input mem_data_t wdata, output mem_rsp_t got,
                               output int cycles, output int psel_cycles,
                               output int write_cycles);
        int guard;
        guard = 0;
        while (!req_ready)
        begin
            if (guard == READY_LIMIT)
            begin
                report_failure("req_ready did not return after the previous response");
            end
            guard++;
            @(negedge clk);
        end
        wait_states <= 3'(next_random() % 5);
        req_valid = 1'b1;
        req.op    = op;
        req.size  = size;
        req.addr  = addr;
        req.wdata = wdata;
        @(negedge clk);
        req_valid    = 1'b0;
        cycles       = 1;
        psel_cycles  = 0;
        write_cycles = 0;
        while (!rsp_valid)
        begin
            if (cycles == RSP_LIMIT)
            begin
                report_failure("no response arrived for an accepted request");
            end
            if (apb.psel)
            begin
                psel_cycles++;
            end
            if (apb.psel && apb.pwrite)
            begin
                write_cycles++;
            end
            wait_states <= 3'(next_random() % 5);
            @(negedge clk);
            cycles++;
        end
        got = rsp;
        @(negedge clk);
        compare_bit("rsp_valid one cycle wide", rsp_valid, 1'b0);
    endtask

    // Runs a request that must succeed and applies it to the reference memory
    task automatic checked_access(input mem_op_t op, input mem_size_t size,
                                  input mem_addr_t addr, input mem_data_t wdata);
        mem_data_t old;
        mem_rsp_t  got;
        int        cycles;
        int        psel_cycles;
        int        write_cycles;
        string     what;
        old  = lane_value(ref_mem[addr[9:2]], addr, size);
        what = $sformatf("%s %s at %h", op.name(), size.name(), addr);
        run_request(op, size, addr, wdata, got, cycles, psel_cycles, write_cycles);
        compare_err({what, " error"}, got.err, ERR_NONE);
        compare_bit({what, " write transfer"}, write_cycles != 0, op != OP_LOAD);
        if (op != OP_STORE)
        begin
            compare_data({what, " data"}, got.rdata, old);
        end
        if (op == OP_STORE)
        begin
            write_lanes(addr, size, wdata);
        end
        else if (op == OP_TAS)
        begin
            write_lanes(addr, size, mem_data_t'(1));
        end
    endtask

    initial
    begin
        mem_rsp_t  got;
        int        cycles;
        int        psel_cycles;
        int        write_cycles;
        mem_addr_t addr;
        mem_size_t size;
        mem_op_t   op;
        clk         = 1'b0;
        reset       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        stall       = 1'b0;
        wait_states <= 3'd0;
        err_lo      = WIN_LO;
        err_hi      = WIN_HI;
        rng         = SEED;

        repeat (16) @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 256; i++)
        begin
            ref_mem[i] = apb_mem_model_inst.mem[i];
        end
        @(negedge clk);
        compare_bit("req_ready after reset", req_ready, 1'b1);
        compare_bit("rsp_valid after reset", rsp_valid, 1'b0);
        compare_bit("PSEL after reset", apb.psel, 1'b0);
        compare_bit("PENABLE after reset", apb.penable, 1'b0);

        // Aligned loads of every size
        repeat (60)
        begin
            size = random_size();
            checked_access(OP_LOAD, size, random_addr(0, int'(WIN_LO), size), '0);
        end

        // Stores read back as whole words
        repeat (40)
        begin
            size = random_size();
            addr = random_addr(0, int'(WIN_LO), size);
            checked_access(OP_STORE, size, addr, next_random());
            checked_access(OP_LOAD, SIZE_WORD, addr & ~mem_addr_t'(3), '0);
        end

        // Second test-and-set on the same lanes sees the 1
        repeat (20)
        begin
            size = random_size();
            addr = random_addr(0, int'(WIN_LO), size);
            checked_access(OP_TAS, size, addr, next_random());
            checked_access(OP_TAS, size, addr, next_random());
            checked_access(OP_LOAD, SIZE_WORD, addr & ~mem_addr_t'(3), '0);
        end

        // Mixed traffic
        repeat (150)
        begin
            op   = mem_op_t'(next_random() % 3);
            size = random_size();
            checked_access(op, size, random_addr(0, int'(WIN_LO), size), next_random());
        end

        // Misaligned requests stay off the bus
        repeat (20)
        begin
            size = (next_random() & 1) ? SIZE_HALF : SIZE_WORD;
            op   = mem_op_t'(next_random() % 3);
            addr = random_addr(0, int'(WIN_LO), SIZE_BYTE);
            if (size == SIZE_HALF)
            begin
                addr[0] = 1'b1;
            end
            else
            begin
                addr[1:0] = 2'(1 + next_random() % 3);
            end
            run_request(op, size, addr, next_random(), got, cycles, psel_cycles,
                        write_cycles);
            compare_err("misaligned error", got.err, ERR_ALIGN);
            compare_count("misaligned PSEL cycles", psel_cycles, 0);
            compare_count("misaligned latency", cycles, 2);
            checked_access(OP_LOAD, SIZE_WORD, addr & ~mem_addr_t'(3), '0);
        end

        // Slave error window
        repeat (12)
        begin
            op   = mem_op_t'(next_random() % 3);
            size = random_size();
            addr = random_addr(WIN_LO, int'(WIN_HI - WIN_LO) + 1, size);
            run_request(op, size, addr, next_random(), got, cycles, psel_cycles,
                        write_cycles);
            compare_err("slave window error", got.err, ERR_SLAVE);
            compare_count("slave window write cycles", write_cycles, 0);
            // Window closed so the word can be read back
            err_lo = 16'hffff;
            err_hi = 16'h0000;
            checked_access(OP_LOAD, SIZE_WORD, addr & ~mem_addr_t'(3), '0);
            err_lo = WIN_LO;
            err_hi = WIN_HI;
        end

        // Stalled slave runs into the bus timeout
        stall = 1'b1;
        addr  = random_addr(0, int'(WIN_LO), SIZE_WORD);
        run_request(OP_LOAD, SIZE_WORD, addr, '0, got, cycles, psel_cycles, write_cycles);
        compare_err("stalled load error", got.err, ERR_TIMEOUT);
        compare_bit("PSEL after timeout", apb.psel, 1'b0);
        run_request(OP_STORE, SIZE_WORD, addr, next_random(), got, cycles, psel_cycles,
                    write_cycles);
        compare_err("stalled store error", got.err, ERR_TIMEOUT);
        compare_count("stalled store write cycles", write_cycles, 0);
        stall = 1'b0;
        checked_access(OP_LOAD, SIZE_WORD, addr, '0);
        size = random_size();
        checked_access(OP_LOAD, size, random_addr(0, int'(WIN_LO), size), '0);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/mem_access_pkg.sv
src/lane_align.sv
src/load_extract.sv
src/store_merge.sv
src/bus_wait_timer.sv
src/mem_access_fsm.sv
src/mem_access_top.sv
tb/apb_mem_model.sv
tb/tb_mem_access.sv

// ==== Makefile ====
VERILATOR       ?= verilator
TOP             ?= tb_mem_access
FILELIST        ?= files.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT       ?= sim passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
